//--- hw/stream_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// stream merge package: field widths,
// vector typedefs and the input and output
// beat structs
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

package stream_pkg;

    // payload bytes per beat
    localparam int tdata_bytes = 2;

    // merged source streams
    localparam int num_sources = 2;

    // sideband widths, fixed for the whole subsystem
    localparam int tdest_width = 2;
    localparam int tuser_width = 1;

    // wide enough to hold any source index
    localparam int source_id_width = (num_sources > 1) ? $clog2(num_sources) : 1;

    // one beat of payload
    typedef logic [tdata_bytes*8-1:0] tdata_t;

    // one valid flag per payload byte
    typedef logic [tdata_bytes-1:0] tkeep_t;

    // routing destination, passed through untouched
    typedef logic [tdest_width-1:0] tdest_t;

    // user sideband, passed through untouched
    typedef logic [tuser_width-1:0] tuser_t;

    // source index written into tid by the arbiter
    typedef logic [source_id_width-1:0] source_id_t;

    // one input beat, 22 bits
    typedef struct packed {
        tdata_t tdata;
        tkeep_t tkeep;
        logic   tlast;
        tdest_t tdest;
        tuser_t tuser;
    } axis_in_t;

    // one output beat, 23 bits
    // tid tells which source the beat came from
    typedef struct packed {
        source_id_t tid;
        axis_in_t   beat;
    } axis_out_t;

endpackage

//--- hw/stream_buffered.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// stream_buffered: zero latency skid buffer
// with a registered ready path
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module stream_buffered #(
    // beat payload, any packed type
    parameter type beat_t = logic
) (
    input  logic  aclk,
    input  logic  reset,

    // upstream side
    input  logic  rx_valid,
    input  beat_t rx_data,
    output logic  rx_ready,

    // downstream side
    output logic  tx_valid,
    output beat_t tx_data,
    input  logic  tx_ready
);

    // one-entry skid register
    beat_t skid_data;

    // skid entry holds a beat
    logic skid_full;

    // beat accepted on rx but not taken by tx in the same cycle
    logic park;

    // held beat taken by tx
    logic drain;

    // the ready flag doubles as the empty flag of the skid entry
    // so rx_ready never depends combinationally on tx_ready
    assign skid_full = ~rx_ready;

    assign park  = rx_valid & rx_ready & ~tx_ready;
    assign drain = skid_full & tx_ready;

    // empty entry: rx passes straight through, zero latency
    // full entry: the held beat goes out first
    always_comb begin
        if (skid_full) begin
            tx_valid = 1'b1;
            tx_data  = skid_data;
        end else begin
            tx_valid = rx_valid;
            tx_data  = rx_data;
        end
    end

    // ready control
    // drops one cycle after a beat is parked, rises one cycle after it drains
    always_ff @(posedge aclk) begin
        if (reset) begin
            rx_ready <= 1'b1;
        end else if (park) begin
            rx_ready <= 1'b0;
        end else if (drain) begin
            rx_ready <= 1'b1;
        end
    end

    // skid payload, only written while the entry is empty
    always_ff @(posedge aclk) begin
        if (park) begin
            skid_data <= rx_data;
        end
    end

endmodule

//--- hw/stream_arbiter.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// stream_arbiter: packet locked round robin
// merge of the source streams, tags each
// beat with its source number
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module stream_arbiter (
    input  logic                  aclk,
    input  logic                  reset,

    // source side, one stream per source
    input  logic                  req_valid [stream_pkg::num_sources],
    input  stream_pkg::axis_in_t  req_data  [stream_pkg::num_sources],
    output logic                  req_ready [stream_pkg::num_sources],

    // merged output
    output logic                  out_valid,
    output stream_pkg::axis_out_t out_data,
    input  logic                  out_ready
);

    // idle: free to pick a new source
    // in_packet: held on lock_src until its tlast beat goes out
    typedef enum logic {
        idle,
        in_packet
    } state_t;

    state_t state;

    // set while a packet is in flight
    logic locked;

    // source that owns the output during a packet
    stream_pkg::source_id_t lock_src;

    // first source to look at when unlocked
    stream_pkg::source_id_t rr_ptr;

    // round robin pick among the current requests
    stream_pkg::source_id_t cand;

    // source driving the output this cycle
    stream_pkg::source_id_t grant;

    // pointer value once the current packet ends
    stream_pkg::source_id_t next_ptr;

    // beat moves out this cycle
    logic xfer;

    assign locked = (state == in_packet);

    // scan from rr_ptr and take the first requester
    // with no requester cand stays on rr_ptr and out_valid stays low
    always_comb begin
        int  idx;
        logic found;
        idx   = 0;
        found = 1'b0;
        cand  = rr_ptr;
        for (int k = 0; k < stream_pkg::num_sources; k++) begin
            idx = (int'(rr_ptr) + k) % stream_pkg::num_sources;
            if (!found && req_valid[idx]) begin
                cand  = stream_pkg::source_id_t'(idx);
                found = 1'b1;
            end
        end
    end

    // grant is purely combinational from the lock state
    assign grant = locked ? lock_src : cand;

    // source after the winner gets first look next time
    assign next_ptr = stream_pkg::source_id_t'((int'(grant) + 1) % stream_pkg::num_sources);

    // output mux, tid carries the winning source number
    always_comb begin
        out_valid     = req_valid[grant];
        out_data.tid  = grant;
        out_data.beat = req_data[grant];
    end

    // only the granted source sees out_ready
    // the others wait with their beat held
    always_comb begin
        for (int i = 0; i < stream_pkg::num_sources; i++) begin
            req_ready[i] = out_ready && (grant == stream_pkg::source_id_t'(i));
        end
    end

    assign xfer = out_valid & out_ready;

    // lock on the first beat of a packet, release after tlast
    // single beat packets never leave idle
    always_ff @(posedge aclk) begin
        if (reset) begin
            state    <= idle;
            lock_src <= '0;
            rr_ptr   <= '0;
        end else if (xfer) begin
            if (out_data.beat.tlast) begin
                state  <= idle;
                rr_ptr <= next_ptr;
            end else if (state == idle) begin
                state    <= in_packet;
                lock_src <= grant;
            end
        end
    end

endmodule

//--- hw/stream_merge_top.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// stream_merge_top: two buffered sources,
// round robin arbiter, buffered output
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module stream_merge_top (
    input  logic                  aclk,
    input  logic                  reset,

    // source streams
    input  logic                  s_valid [stream_pkg::num_sources],
    input  stream_pkg::axis_in_t  s_data  [stream_pkg::num_sources],
    output logic                  s_ready [stream_pkg::num_sources],

    // merged output stream
    output logic                  m_valid,
    output stream_pkg::axis_out_t m_data,
    input  logic                  m_ready
);

    // input buffers to arbiter
    logic                 arb_valid [stream_pkg::num_sources];
    stream_pkg::axis_in_t arb_data  [stream_pkg::num_sources];
    logic                 arb_ready [stream_pkg::num_sources];

    // arbiter to output buffer
    logic                  mux_valid;
    stream_pkg::axis_out_t mux_data;
    logic                  mux_ready;

    // one buffer per source
    // keeps the arbiter's combinational ready off the source ports
    for (genvar i = 0; i < stream_pkg::num_sources; i++) begin : in_buf
        stream_buffered #(
            .beat_t (stream_pkg::axis_in_t)
        ) stage (
            .aclk     (aclk),
            .reset    (reset),
            .rx_valid (s_valid[i]),
            .rx_data  (s_data[i]),
            .rx_ready (s_ready[i]),
            .tx_valid (arb_valid[i]),
            .tx_data  (arb_data[i]),
            .tx_ready (arb_ready[i])
        );
    end

    // packet level merge onto the shared stream
    stream_arbiter arbiter (
        .aclk      (aclk),
        .reset     (reset),
        .req_valid (arb_valid),
        .req_data  (arb_data),
        .req_ready (arb_ready),
        .out_valid (mux_valid),
        .out_data  (mux_data),
        .out_ready (mux_ready)
    );

    // output buffer
    // consumer ready stops here and never reaches the arbiter directly
    stream_buffered #(
        .beat_t (stream_pkg::axis_out_t)
    ) out_buf (
        .aclk     (aclk),
        .reset    (reset),
        .rx_valid (mux_valid),
        .rx_data  (mux_data),
        .rx_ready (mux_ready),
        .tx_valid (m_valid),
        .tx_data  (m_data),
        .tx_ready (m_ready)
    );

endmodule

//--- dv/stream_merge_properties.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// handshake assertions for the merge top
// and their bind into stream_merge_top
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module stream_merge_properties (
    input logic                  aclk,
    input logic                  reset,
    input logic                  s_valid [stream_pkg::num_sources],
    input stream_pkg::axis_in_t  s_data  [stream_pkg::num_sources],
    input logic                  s_ready [stream_pkg::num_sources],
    input logic                  m_valid,
    input stream_pkg::axis_out_t m_data,
    input logic                  m_ready
);

    // failed assertion count read by the testbench
    int fail_count = 0;

    // output is between the first and the tlast beat of a packet
    logic mid_packet;
    stream_pkg::source_id_t pkt_tid;

    always_ff @(posedge aclk) begin
        if (reset) begin
            mid_packet <= 1'b0;
        end else if (m_valid && m_ready) begin
            mid_packet <= ~m_data.beat.tlast;
            pkt_tid    <= m_data.tid;
        end
    end

    // stalled output beat holds
    out_hold: assert property (@(posedge aclk) disable iff (reset)
        m_valid && !m_ready |=> m_valid && $stable(m_data))
        else begin
            fail_count++;
            $error("m_valid or m_data moved while stalled");
        end

    // same rule on every source port
    for (genvar i = 0; i < stream_pkg::num_sources; i++) begin : src_rule
        in_hold: assert property (@(posedge aclk) disable iff (reset)
            s_valid[i] && !s_ready[i] |=> s_valid[i] && $stable(s_data[i]))
            else begin
                fail_count++;
                $error("source %0d moved while stalled", i);
            end
    end

    // one source per output packet
    tid_lock: assert property (@(posedge aclk) disable iff (reset)
        m_valid && m_ready && mid_packet |-> m_data.tid == pkt_tid)
        else begin
            fail_count++;
            $error("tid changed inside an output packet");
        end

    // nothing on the output right after reset
    reset_quiet: assert property (@(posedge aclk) $fell(reset) |-> !m_valid)
        else begin
            fail_count++;
            $error("m_valid high in the cycle after reset");
        end

endmodule

bind stream_merge_top stream_merge_properties props_i (
    .aclk    (aclk),
    .reset   (reset),
    .s_valid (s_valid),
    .s_data  (s_data),
    .s_ready (s_ready),
    .m_valid (m_valid),
    .m_data  (m_data),
    .m_ready (m_ready)
);

//--- dv/stream_merge_tb.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// testbench for the merge top with table
// driven sources, back-pressure and a
// per source scoreboard
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module stream_merge_tb;

    // one packet with source, length, first word, last keep, dest, user and stall percent
    typedef struct packed {
        int source;
        int length;
        stream_pkg::tdata_t first_word;
        stream_pkg::tkeep_t last_keep;
        stream_pkg::tdest_t dest;
        stream_pkg::tuser_t user;
        int stall_pct;
    } row_t;

    localparam int num_rows = 16;
    localparam int num_phases = 5;

    localparam row_t rows [num_rows] = '{
        '{0, 3, 16'h1000, 2'b01, 2'd1, 1'b0, 0}, '{0, 1, 16'h1100, 2'b11, 2'd2, 1'b1, 0},
        '{1, 2, 16'h2000, 2'b10, 2'd3, 1'b1, 0}, '{1, 4, 16'h2100, 2'b01, 2'd0, 1'b0, 0},
        '{0, 2, 16'h3000, 2'b11, 2'd0, 1'b1, 0}, '{1, 3, 16'h4000, 2'b01, 2'd1, 1'b0, 0},
        '{0, 4, 16'h3100, 2'b10, 2'd2, 1'b0, 0}, '{1, 1, 16'h4100, 2'b11, 2'd3, 1'b1, 0},
        '{0, 3, 16'h5000, 2'b01, 2'd0, 1'b0, 30}, '{1, 2, 16'h6000, 2'b11, 2'd1, 1'b1, 30},
        '{0, 2, 16'h5100, 2'b10, 2'd2, 1'b1, 30}, '{1, 4, 16'h6100, 2'b01, 2'd3, 1'b0, 30},
        '{0, 2, 16'h7000, 2'b11, 2'd1, 1'b0, 70}, '{1, 3, 16'h8000, 2'b10, 2'd2, 1'b1, 70},
        '{0, 1, 16'h7100, 2'b01, 2'd3, 1'b1, 70}, '{1, 2, 16'h8100, 2'b11, 2'd0, 1'b0, 70}
    };

    // phases in order are source 0 alone, source 1 alone, contention,
    // then 30 and 70 percent stall
    localparam int phase_first [num_phases] = '{0, 2, 4, 8, 12};
    localparam int phase_last  [num_phases] = '{1, 3, 7, 11, 15};
    localparam int phase_solo  [num_phases] = '{0, 1, -1, -1, -1};
    localparam bit phase_rr    [num_phases] = '{0, 0, 1, 0, 0};

    logic                  aclk;
    logic                  reset;
    logic                  s_valid [stream_pkg::num_sources];
    stream_pkg::axis_in_t  s_data  [stream_pkg::num_sources];
    logic                  s_ready [stream_pkg::num_sources];
    logic                  m_valid;
    stream_pkg::axis_out_t m_data;
    logic                  m_ready;

    // expected beats per source in order
    stream_pkg::axis_in_t exp_q [stream_pkg::num_sources][$];

    int mismatch_count = 0;
    int other_count = 0;
    int timeout_count = 0;
    int out_beats = 0;
    int total_beats = 0;
    int cycles = 0;
    int cycle_limit = 200;
    int stall_pct = 0;
    int solo_src = -1;
    bit rr_check = 1'b0;

    // output scoreboard state
    bit in_packet = 1'b0;
    stream_pkg::source_id_t pkt_src = '0;
    stream_pkg::source_id_t rr_model = '0;

    stream_merge_top stream_merge_i (.*);

    initial begin
        aclk = 1'b0;
        forever #5 aclk = ~aclk;
    end

    always @(posedge aclk) begin
        cycles++;
        if (cycles > cycle_limit) begin
            $display("timeout: run still busy after %0d cycles", cycle_limit);
            timeout_count++;
            finish_run();
        end
    end

    // random consumer stall
    always @(negedge aclk) begin
        m_ready = int'($urandom % 100) >= stall_pct;
    end

    task automatic compare_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            mismatch_count++;
            $display("Mismatch %s: got %h expected %h", name, got, exp);
        end
    endtask

    task automatic compare_tid(input stream_pkg::source_id_t got,
                               input stream_pkg::source_id_t exp);
        if (got !== exp) begin
            mismatch_count++;
            $display("Mismatch m_data.tid: got %h expected %h", got, exp);
        end
    endtask

    // fields in order tdata tkeep tlast tdest tuser
    task automatic compare_beat(input stream_pkg::axis_in_t got,
                                input stream_pkg::axis_in_t exp);
        if (got !== exp) begin
            mismatch_count++;
            $display("Mismatch m_data.beat: got %h %h %h %h %h expected %h %h %h %h %h",
                     got.tdata, got.tkeep, got.tlast, got.tdest, got.tuser,
                     exp.tdata, exp.tkeep, exp.tlast, exp.tdest, exp.tuser);
        end
    endtask

    // plays one source's rows of a row range back to back
    task automatic drive_source(input int src, input int first_row, input int last_row);
        stream_pkg::axis_in_t beat;
        for (int r = first_row; r <= last_row; r++) begin
            if (rows[r].source == src) begin
                stall_pct = rows[r].stall_pct;
                for (int b = 0; b < rows[r].length; b++) begin
                    beat.tdata = (b == 0) ? rows[r].first_word : stream_pkg::tdata_t'($urandom);
                    beat.tlast = (b == rows[r].length - 1);
                    beat.tkeep = beat.tlast ? rows[r].last_keep : '1;
                    beat.tdest = rows[r].dest;
                    beat.tuser = rows[r].user;
                    exp_q[src].push_back(beat);
                    s_valid[src] = 1'b1;
                    s_data[src]  = beat;
                    // s_ready is registered, so it is stable here
                    while (!s_ready[src]) @(negedge aclk);
                    @(negedge aclk);
                end
            end
        end
        s_valid[src] = 1'b0;
    endtask

    // one output transfer against the queue of the source named by tid
    task automatic check_output(input stream_pkg::axis_out_t got);
        int src;
        src = int'(got.tid);
        out_beats++;
        if (in_packet) begin
            compare_tid(got.tid, pkt_src);
        end else if (rr_check) begin
            compare_tid(got.tid, rr_model);
        end else if (solo_src >= 0) begin
            compare_tid(got.tid, stream_pkg::source_id_t'(solo_src));
        end
        if (exp_q[src].size() == 0) begin
            other_count++;
            $display("output beat from source %0d arrived with nothing expected", src);
        end else begin
            compare_beat(got.beat, exp_q[src].pop_front());
        end
        // next packet goes to the source after the expected winner
        if (got.beat.tlast) begin
            in_packet = 1'b0;
            if (rr_check) begin
                rr_model = stream_pkg::source_id_t'(
                    (int'(rr_model) + 1) % stream_pkg::num_sources);
            end else if (solo_src >= 0) begin
                rr_model = stream_pkg::source_id_t'(
                    (solo_src + 1) % stream_pkg::num_sources);
            end
        end else if (!in_packet) begin
            in_packet = 1'b1;
            pkt_src   = got.tid;
        end
    endtask

    // sample between edges after the negedge drivers settled
    initial begin
        forever begin
            @(negedge aclk);
            #2;
            if (!reset && m_valid && m_ready) begin
                check_output(m_data);
            end
        end
    end

    task automatic finish_run();
        $display("errors: mismatches=%0d lost_or_extra=%0d assertions=%0d timeouts=%0d",
                 mismatch_count, other_count, stream_merge_i.props_i.fail_count,
                 timeout_count);
        if (mismatch_count + other_count + timeout_count
            + stream_merge_i.props_i.fail_count == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    endtask

    initial begin
        void'($urandom(32'h9171_8089));
        reset = 1'b1;
        m_ready = 1'b1;
        for (int i = 0; i < stream_pkg::num_sources; i++) begin
            s_valid[i] = 1'b0;
            s_data[i]  = '0;
        end
        for (int r = 0; r < num_rows; r++) begin
            total_beats += rows[r].length;
        end
        cycle_limit = 4 * total_beats + 200;
        repeat (4) @(negedge aclk);
        reset = 1'b0;
        #1;
        compare_flag("m_valid", m_valid, 1'b0);
        for (int i = 0; i < stream_pkg::num_sources; i++) begin
            compare_flag($sformatf("s_ready[%0d]", i), s_ready[i], 1'b1);
        end
        for (int p = 0; p < num_phases; p++) begin
            solo_src = phase_solo[p];
            rr_check = phase_rr[p];
            @(negedge aclk);
            fork
                drive_source(0, phase_first[p], phase_last[p]);
                drive_source(1, phase_first[p], phase_last[p]);
            join
            // let the phase drain before the next one starts
            while (exp_q[0].size() != 0 || exp_q[1].size() != 0) @(negedge aclk);
            repeat (3) @(negedge aclk);
        end
        if (out_beats != total_beats) begin
            other_count++;
            $display("output carried %0d beats but the table holds %0d", out_beats, total_beats);
        end
        finish_run();
    end

endmodule

//--- src.f
hw/stream_pkg.sv
hw/stream_buffered.sv
hw/stream_arbiter.sv
hw/stream_merge_top.sv
dv/stream_merge_properties.sv
dv/stream_merge_tb.sv
